/* files.f */
src/starforce_pkg.sv
src/core_settings.sv
src/reset_stretch.sv
src/coin_pulse.sv
src/player_input_mux.sv
src/video_formatter.sv
src/starforce_core_top.sv
bench/tb_starforce.sv

/* run_sim.sh */
#!/bin/sh
# builds the Star Force wrapper testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_starforce \
    -f files.f -o tb_starforce
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_starforce > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TEST RESULT: FAIL" "$log"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

/* bench/tb_starforce.sv */
// self-checking testbench for the Star Force clk_74a wrapper
// drives bridge writes, pads and pixels into starforce_core_top
// routing vectors come from a table, stick values from a seeded $random

`timescale 1ns/1ns

module tb_starforce
    import starforce_pkg::*;
();

    localparam int reset_len  = 16;
    localparam int coin_len   = 12;
    localparam int wait_limit = 200;

    // fixed pad contents for the routing table
    localparam pad_keys_t c1_keys = 16'h0101;
    localparam pad_keys_t c2_keys = 16'h0202;
    localparam pad_keys_t a1_keys = 16'h100C;
    localparam pad_keys_t a2_keys = 16'h2013;

    // one routing vector, sticks as {y, x}
    typedef struct packed {
        logic [4:0]  cfg;
        pad_keys_t   c1;
        pad_keys_t   c2;
        pad_keys_t   k1;
        logic [15:0] s1;
        pad_keys_t   k2;
        logic [15:0] s2;
        pad_keys_t   e1;
        pad_keys_t   e2;
    } route_row_t;

    logic         clk_74a;
    logic         rst_n;
    bridge_word_t bridge_addr;
    logic         bridge_wr;
    bridge_word_t bridge_wr_data;
    bridge_word_t bridge_rd_data;
    game_dips_t   dip_word;
    logic         core_reset;
    pad_keys_t    cont1_key;
    pad_keys_t    cont2_key;
    snac_pad_t    snac_p1;
    snac_pad_t    snac_p2;
    pad_keys_t    p1_controls;
    pad_keys_t    p2_controls;
    arcade_ctrl_t arcade_ctrl;
    pixel_in_t    pixel_in;
    pixel_out_t   pixel_out;

    integer     seed    = 634;
    logic       hs_last = 1'b0;
    logic       vs_last = 1'b0;
    route_row_t routes[$];

    starforce_core_top #(
        .RESET_CYCLES (reset_len),
        .COIN_CYCLES  (coin_len)
    ) UUT (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .dip_word       (dip_word),
        .core_reset     (core_reset),
        .cont1_key      (cont1_key),
        .cont2_key      (cont2_key),
        .snac_p1        (snac_p1),
        .snac_p2        (snac_p2),
        .p1_controls    (p1_controls),
        .p2_controls    (p2_controls),
        .arcade_ctrl    (arcade_ctrl),
        .pixel_in       (pixel_in),
        .pixel_out      (pixel_out)
    );

    // 4 ns period
    initial begin
        clk_74a = 1'b0;
        forever #2 clk_74a = ~clk_74a;
    end

    //////////////////////////////
    // checking helpers
    //////////////////////////////

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout on %s", what);
    endtask

    // 0 selects core_reset, anything else the coin bit
    function automatic logic pulse_level(input int which);
        return (which == 0) ? core_reset : arcade_ctrl.coin;
    endfunction

    // cycles until the pulse goes high
    task automatic wait_rise(input int which, input string name, output int delay);
        delay = 0;
        while (!pulse_level(which) && delay < wait_limit) begin
            @(negedge clk_74a);
            delay++;
        end
        assert (pulse_level(which)) else report_timeout({name, " rising"});
    endtask

    // cycles the pulse stays high
    task automatic count_high(input int which, input string name, output int width);
        width = 0;
        while (pulse_level(which) && width < wait_limit) begin
            @(negedge clk_74a);
            width++;
        end
        assert (!pulse_level(which)) else report_timeout({name, " falling"});
    endtask

    //////////////////////////////
    // expected value models
    //////////////////////////////

    // nibble repeated into a byte
    function automatic logic [23:0] expand_rgb(input logic [11:0] c);
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    // threshold classification, x in [7:0], y in [15:8]
    function automatic pad_keys_t stick_dpad(input logic [15:0] stick);
        pad_keys_t k;
        k = '0;
        k[key_up]    = stick[15:8] < stick_low;
        k[key_down]  = stick[15:8] > stick_high;
        k[key_left]  = stick[7:0] < stick_low;
        k[key_right] = stick[7:0] > stick_high;
        return k;
    endfunction

    function automatic arcade_ctrl_t ctrl_word(input pad_keys_t k, input logic coin);
        arcade_ctrl_t w;
        w.up    = k[key_up];
        w.down  = k[key_down];
        w.left  = k[key_left];
        w.right = k[key_right];
        w.fire  = k[key_fire];
        w.start = k[key_start];
        w.coin  = coin;
        return w;
    endfunction

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // one-cycle strobe, register visible at the next falling edge
    task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data);
        @(negedge clk_74a);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
    endtask

    // readback is combinational, sample inside the low phase
    task automatic bridge_read(input bridge_word_t addr, output bridge_word_t data);
        @(negedge clk_74a);
        bridge_addr = addr;
        #1;
        data = bridge_rd_data;
    endtask

    function automatic void add_route(input logic [4:0] cfg, input pad_keys_t c1,
                                      input pad_keys_t c2, input pad_keys_t k1,
                                      input logic [15:0] s1, input pad_keys_t k2,
                                      input logic [15:0] s2, input pad_keys_t e1,
                                      input pad_keys_t e2);
        route_row_t r;
        r = {cfg, c1, c2, k1, s1, k2, s2, e1, e2};
        routes.push_back(r);
    endfunction

    // settings first, then pads, outputs one cycle later
    task automatic apply_route(input route_row_t r, input string name);
        bridge_write(addr_snac, {27'h0, r.cfg});
        cont1_key     = r.c1;
        cont2_key     = r.c2;
        snac_p1.keys  = r.k1;
        snac_p1.stick = {16'h0, r.s1};
        snac_p2.keys  = r.k2;
        snac_p2.stick = {16'h0, r.s2};
        @(negedge clk_74a);
        check({name, " p1"}, 32'(r.e1), 32'(p1_controls));
        check({name, " p2"}, 32'(r.e2), 32'(p2_controls));
    endtask

    // 16 pixels, two short hblanks, vblank at the end
    task automatic video_pass(input logic blank_req, input string name);
        pixel_in_t   pix;
        pixel_out_t  px_exp;
        logic [31:0] rnd;
        @(negedge clk_74a);
        for (int i = 0; i < 16; i++) begin
            rnd        = $random(seed);
            pix.rgb12  = rnd[11:0];
            pix.hblank = (i % 8) >= 6;
            pix.vblank = i >= 12;
            pix.hs     = (i % 8) >= 6;
            pix.vs     = i >= 12;
            pixel_in   = pix;
            px_exp.de    = !(pix.hblank || pix.vblank);
            px_exp.rgb24 = (px_exp.de && !blank_req) ? expand_rgb(pix.rgb12) : 24'h0;
            px_exp.hs    = pix.hs && !hs_last;
            px_exp.vs    = pix.vs && !vs_last;
            hs_last      = pix.hs;
            vs_last      = pix.vs;
            @(negedge clk_74a);
            check($sformatf("%s %0d", name, i), 32'(px_exp), 32'(pixel_out));
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        route_row_t   row;
        bridge_word_t rd;
        bridge_word_t d_lives;
        bridge_word_t d_diff;
        bridge_word_t d_bonus;
        bridge_word_t d_demo;
        logic [31:0]  rnd;
        int           delay;
        int           width;
        rst_n          = 1'b0;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        snac_p1        = '0;
        snac_p2        = '0;
        pixel_in       = '0;
        repeat (8) @(posedge clk_74a);
        @(negedge clk_74a);

        // reset values, sampled before release
        check("reset core_reset", 32'(1'b0), 32'(core_reset));
        check("reset dip_word", 32'h0, 32'(dip_word));
        check("reset p1_controls", 32'h0, 32'(p1_controls));
        check("reset p2_controls", 32'h0, 32'(p2_controls));
        check("reset arcade_ctrl", 32'h0, 32'(arcade_ctrl));
        check("reset pixel_out", 32'h0, 32'(pixel_out));
        rst_n = 1'b1;
        bridge_read(addr_snac, rd);
        check("reset snac readback", 32'h0, rd);

        // dips take the low data bits only
        d_lives = 32'hFFFF_FFFE;
        d_diff  = 32'h0000_00FD;
        d_bonus = 32'h1234_5676;
        d_demo  = 32'h8000_0003;
        bridge_write(addr_lives, d_lives);
        bridge_write(addr_difficulty, d_diff);
        bridge_write(addr_bonus, d_bonus);
        bridge_write(addr_demo, d_demo);
        check("dip word", 32'({d_lives[1:0], d_diff[2:0], d_bonus[2:0], d_demo[0]}),
              32'(dip_word));
        bridge_write(addr_snac, 32'hFFFF_FFF5);
        bridge_read(addr_snac, rd);
        check("snac readback", 32'hFFFF_FFF5 & 32'h1F, rd);
        bridge_read(addr_lives, rd);
        check("lives readback", 32'h0, rd);
        bridge_read(32'h1234_5678, rd);
        check("unmapped readback", 32'h0, rd);

        //////////////////////////////
        // routing table
        //////////////////////////////

        // cfg bits: blank, assign[1:0], analog, enable
        add_route(5'h00, c1_keys, c2_keys, a1_keys, 16'h3F3F, a2_keys, 16'h0000,
                  16'h0101, 16'h0202);
        add_route(5'h02, c1_keys, c2_keys, a1_keys, 16'h3F3F, a2_keys, 16'h0000,
                  16'h0101, 16'h0202);
        add_route(5'h01, c1_keys, c2_keys, a1_keys, 16'hC13F, a2_keys, 16'h0000,
                  16'h100C, 16'h0101);
        add_route(5'h03, c1_keys, c2_keys, a1_keys, 16'hC13F, a2_keys, 16'h0000,
                  16'h1006, 16'h0101);
        add_route(5'h05, c1_keys, c2_keys, a1_keys, 16'hC13F, a2_keys, 16'h0000,
                  16'h0101, 16'h100C);
        // p1_to_p2 ignores analog
        add_route(5'h07, c1_keys, c2_keys, a1_keys, 16'hC13F, a2_keys, 16'h0000,
                  16'h0101, 16'h100C);
        add_route(5'h09, c1_keys, c2_keys, a1_keys, 16'hC13F, a2_keys, 16'h00FF,
                  16'h100C, 16'h2013);
        // thresholds themselves give no direction
        add_route(5'h0B, c1_keys, c2_keys, a1_keys, 16'hC040, a2_keys, 16'h00FF,
                  16'h1000, 16'h2019);
        add_route(5'h0D, c1_keys, c2_keys, a1_keys, 16'hC13F, a2_keys, 16'h8080,
                  16'h2013, 16'h100C);
        add_route(5'h0F, c1_keys, c2_keys, a1_keys, 16'hC13F, a2_keys, 16'h8080,
                  16'h2010, 16'h1006);
        add_route(5'h0E, c1_keys, c2_keys, a1_keys, 16'hC13F, a2_keys, 16'h8080,
                  16'h0101, 16'h0202);
        foreach (routes[i]) begin
            apply_route(routes[i], $sformatf("route row %0d", i));
        end

        // random sticks, direct and swapped analog
        for (int i = 0; i < 16; i++) begin
            rnd    = $random(seed);
            row.s1 = rnd[15:0];
            row.s2 = rnd[31:16];
            row.cfg = i[0] ? 5'h0F : 5'h0B;
            row.c1  = c1_keys;
            row.c2  = c2_keys;
            row.k1  = a1_keys;
            row.k2  = a2_keys;
            row.e1  = (a1_keys & 16'hFFF0) | stick_dpad(row.s1);
            row.e2  = (a2_keys & 16'hFFF0) | stick_dpad(row.s2);
            if (i[0]) begin
                row = {row.cfg, row.c1, row.c2, row.k1, row.s1, row.k2, row.s2,
                       row.e2, row.e1};
            end
            apply_route(row, $sformatf("random stick %0d", i));
        end

        //////////////////////////////
        // manual reset and coin
        //////////////////////////////

        // data is ignored, each write flips the toggle
        bridge_write(addr_reset, 32'hDEAD_BEEF);
        wait_rise(0, "core_reset", delay);
        check("reset 1 delay", 1, delay);
        count_high(0, "core_reset", width);
        check("reset 1 width", reset_len, width);
        bridge_write(addr_reset, 32'h0);
        wait_rise(0, "core_reset", delay);
        check("reset 2 delay", 1, delay);
        count_high(0, "core_reset", width);
        check("reset 2 width", reset_len, width);

        // handheld pad straight through with adapter off
        bridge_write(addr_snac, 32'h0);
        cont1_key = 16'hC011;
        @(negedge clk_74a);
        check("coin press p1", 32'h0000_C011, 32'(p1_controls));
        check("coin press arcade", 32'(ctrl_word(16'hC011, 1'b0)), 32'(arcade_ctrl));
        cont1_key = 16'h8011;
        // one cycle through the mux, one to detect the release
        wait_rise(1, "coin", delay);
        check("coin delay", 2, delay);
        check("coin arcade", 32'(ctrl_word(16'h8011, 1'b1)), 32'(arcade_ctrl));
        count_high(1, "coin", width);
        check("coin width", coin_len, width);

        //////////////////////////////
        // video
        //////////////////////////////

        video_pass(1'b0, "video");
        bridge_write(addr_snac, 32'h11);
        video_pass(1'b1, "video blanked");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* src/starforce_core_top.sv */
// clk_74a side of the Star Force core wrapper
// settings block feeding reset, controls and video paths
// pulse lengths set here, shortened by the testbench

`timescale 1ns/1ns

module starforce_core_top
    import starforce_pkg::*;
#(
    parameter int RESET_CYCLES = 32'h200000,
    parameter int COIN_CYCLES  = 32'hFFFFF
) (
    input  logic         clk_74a,
    input  logic         rst_n,
    input  bridge_word_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_word_t bridge_wr_data,
    output bridge_word_t bridge_rd_data,
    output game_dips_t   dip_word,
    output logic         core_reset,
    input  pad_keys_t    cont1_key,
    input  pad_keys_t    cont2_key,
    input  snac_pad_t    snac_p1,
    input  snac_pad_t    snac_p2,
    output pad_keys_t    p1_controls,
    output pad_keys_t    p2_controls,
    output arcade_ctrl_t arcade_ctrl,
    input  pixel_in_t    pixel_in,
    output pixel_out_t   pixel_out
);

    snac_cfg_t snac_cfg;
    logic      reset_toggle;
    logic      coin_active;

    //////////////////////////////
    // settings and reset
    //////////////////////////////

    core_settings u_settings (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .dips           (dip_word),
        .snac_cfg       (snac_cfg),
        .reset_toggle   (reset_toggle)
    );

    reset_stretch #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_reset_stretch (
        .clk_74a      (clk_74a),
        .rst_n        (rst_n),
        .reset_toggle (reset_toggle),
        .core_reset   (core_reset)
    );

    //////////////////////////////
    // controls
    //////////////////////////////

    player_input_mux u_input_mux (
        .clk_74a     (clk_74a),
        .rst_n       (rst_n),
        .snac_cfg    (snac_cfg),
        .cont1_key   (cont1_key),
        .cont2_key   (cont2_key),
        .snac_p1     (snac_p1),
        .snac_p2     (snac_p2),
        .p1_controls (p1_controls),
        .p2_controls (p2_controls)
    );

    // coin from player 1 select
    coin_pulse #(
        .COIN_CYCLES (COIN_CYCLES)
    ) u_coin_pulse (
        .clk_74a     (clk_74a),
        .rst_n       (rst_n),
        .coin        (p1_controls[key_coin]),
        .coin_active (coin_active)
    );

    // arcade word up..coin, player 1 only
    assign arcade_ctrl.up    = p1_controls[key_up];
    assign arcade_ctrl.down  = p1_controls[key_down];
    assign arcade_ctrl.left  = p1_controls[key_left];
    assign arcade_ctrl.right = p1_controls[key_right];
    assign arcade_ctrl.fire  = p1_controls[key_fire];
    assign arcade_ctrl.start = p1_controls[key_start];
    assign arcade_ctrl.coin  = coin_active;

    //////////////////////////////
    // video
    //////////////////////////////

    video_formatter u_video (
        .clk_74a   (clk_74a),
        .rst_n     (rst_n),
        .snac_cfg  (snac_cfg),
        .pixel_in  (pixel_in),
        .pixel_out (pixel_out)
    );

endmodule

/* src/video_formatter.sv */
// formats the 12-bit arcade pixel for the scaler
// widens colour, builds de and one-cycle sync pulses
// one register stage from pixel_in to pixel_out

`timescale 1ns/1ns

module video_formatter
    import starforce_pkg::*;
(
    input  logic       clk_74a,
    input  logic       rst_n,
    input  snac_cfg_t  snac_cfg,
    input  pixel_in_t  pixel_in,
    output pixel_out_t pixel_out
);

    logic hs_prev;
    logic vs_prev;
    logic active;
    logic blank_req;

    assign active    = !(pixel_in.hblank || pixel_in.vblank);
    // adapter asks for a dark handheld screen
    assign blank_req = snac_cfg.enable && snac_cfg.blank_screen;

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            pixel_out <= '0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
        end else begin
            pixel_out.de    <= active;
            pixel_out.rgb24 <= '0;
            // nibble repeated gives full 8-bit range
            if (active && !blank_req) begin
                pixel_out.rgb24 <= {{2{pixel_in.rgb12[11:8]}},
                                    {2{pixel_in.rgb12[7:4]}},
                                    {2{pixel_in.rgb12[3:0]}}};
            end
            // rising edges only
            pixel_out.hs <= pixel_in.hs && !hs_prev;
            pixel_out.vs <= pixel_in.vs && !vs_prev;
            hs_prev      <= pixel_in.hs;
            vs_prev      <= pixel_in.vs;
        end
    end

endmodule

/* src/player_input_mux.sv */
// routes handheld or adapter pads onto players 1 and 2
// analog adapters get their d-pad from the left stick
// outputs registered, one cycle behind the inputs

`timescale 1ns/1ns

module player_input_mux
    import starforce_pkg::*;
(
    input  logic      clk_74a,
    input  logic      rst_n,
    input  snac_cfg_t snac_cfg,
    input  pad_keys_t cont1_key,
    input  pad_keys_t cont2_key,
    input  snac_pad_t snac_p1,
    input  snac_pad_t snac_p2,
    output pad_keys_t p1_controls,
    output pad_keys_t p2_controls
);

    // adapter keys, d-pad replaced by stick when analog
    function automatic pad_keys_t adapter_keys(input snac_pad_t pad, input logic analog);
        pad_keys_t  keys;
        logic [7:0] stick_x;
        logic [7:0] stick_y;
        keys    = pad.keys;
        stick_x = pad.stick[7:0];
        stick_y = pad.stick[15:8];
        if (analog) begin
            // low values are up / left
            keys[key_up]    = stick_y < stick_low;
            keys[key_down]  = stick_y > stick_high;
            keys[key_left]  = stick_x < stick_low;
            keys[key_right] = stick_x > stick_high;
        end
        return keys;
    endfunction

    pad_keys_t snac1_keys;
    pad_keys_t snac2_keys;

    assign snac1_keys = adapter_keys(snac_p1, snac_cfg.analog);
    assign snac2_keys = adapter_keys(snac_p2, snac_cfg.analog);

    //////////////////////////////
    // routing
    //////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            p1_controls <= '0;
            p2_controls <= '0;
        end else if (!snac_cfg.enable) begin
            // adapter off, handheld pads only
            p1_controls <= cont1_key;
            p2_controls <= cont2_key;
        end else begin
            case (snac_cfg.assign_mode)
                p1_to_p1: begin
                    p1_controls <= snac1_keys;
                    p2_controls <= cont1_key;
                end
                // adapter pad 1 goes through raw here
                p1_to_p2: begin
                    p1_controls <= cont1_key;
                    p2_controls <= snac_p1.keys;
                end
                both_direct: begin
                    p1_controls <= snac1_keys;
                    p2_controls <= snac2_keys;
                end
                both_swapped: begin
                    p1_controls <= snac2_keys;
                    p2_controls <= snac1_keys;
                end
            endcase
        end
    end

endmodule

/* src/coin_pulse.sv */
// turns a coin button release into a long coin pulse
// the arcade core samples coin slowly, so a short press needs stretching

`timescale 1ns/1ns

module coin_pulse
    import starforce_pkg::*;
#(
    parameter int COIN_CYCLES = 32'hFFFFF
) (
    input  logic clk_74a,
    input  logic rst_n,
    input  logic coin,
    output logic coin_active
);

    localparam int CNT_W = $clog2(COIN_CYCLES + 1);

    logic             coin_prev;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            coin_prev   <= 1'b0;
            coin_active <= 1'b0;
            count       <= '0;
        end else begin
            coin_prev <= coin;
            if (coin_active) begin
                // edges here are swallowed
                if (count == '0) begin
                    coin_active <= 1'b0;
                end else begin
                    count <= count - 1'b1;
                end
            end else if (coin_prev && !coin) begin
                coin_active <= 1'b1;
                count       <= CNT_W'(COIN_CYCLES - 1);
            end
        end
    end

endmodule

/* src/reset_stretch.sv */
// stretches a flip of the reset toggle into a long core reset
// toggles arriving while the reset runs are dropped

`timescale 1ns/1ns

module reset_stretch
    import starforce_pkg::*;
#(
    parameter int RESET_CYCLES = 32'h200000
) (
    input  logic clk_74a,
    input  logic rst_n,
    input  logic reset_toggle,
    output logic core_reset
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic             last_toggle;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            last_toggle <= 1'b0;
            core_reset  <= 1'b0;
            count       <= '0;
        end else begin
            // track level always so a mid-pulse flip is lost
            last_toggle <= reset_toggle;
            if (core_reset) begin
                if (count == '0) begin
                    core_reset <= 1'b0;
                end else begin
                    count <= count - 1'b1;
                end
            end else if (reset_toggle != last_toggle) begin
                core_reset <= 1'b1;
                count      <= CNT_W'(RESET_CYCLES - 1);
            end
        end
    end

endmodule

/* src/core_settings.sv */
// settings register file written by the host bridge
// holds the game dips, the reset toggle and the adapter word
// only the adapter word is readable

`timescale 1ns/1ns

module core_settings
    import starforce_pkg::*;
(
    input  logic         clk_74a,
    input  logic         rst_n,
    input  bridge_word_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_word_t bridge_wr_data,
    output bridge_word_t bridge_rd_data,
    output game_dips_t   dips,
    output snac_cfg_t    snac_cfg,
    output logic         reset_toggle
);

    //////////////////////////////
    // write decode
    //////////////////////////////

    // one strobe, one register, visible next cycle
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            dips         <= '0;
            snac_cfg     <= '0;
            reset_toggle <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                addr_lives: begin
                    dips.lives <= bridge_wr_data[1:0];
                end
                addr_difficulty: begin
                    dips.difficulty <= bridge_wr_data[2:0];
                end
                addr_bonus: begin
                    dips.bonus <= bridge_wr_data[2:0];
                end
                addr_demo: begin
                    dips.demo_sounds <= bridge_wr_data[0];
                end
                // data ignored, any write flips it
                addr_reset: begin
                    reset_toggle <= ~reset_toggle;
                end
                // enable, analog, assign, blank in bits 4..0
                addr_snac: begin
                    snac_cfg <= snac_cfg_t'(bridge_wr_data[$bits(snac_cfg_t)-1:0]);
                end
                default: begin
                end
            endcase
        end
    end

    //////////////////////////////
    // readback
    //////////////////////////////

    // combinational from address, zero elsewhere
    always_comb begin
        bridge_rd_data = '0;
        if (bridge_addr == addr_snac) begin
            bridge_rd_data[$bits(snac_cfg_t)-1:0] = snac_cfg;
        end
    end

endmodule

/* src/starforce_pkg.sv */
// shared types and constants for the Star Force wrapper logic
// bridge map, adapter settings, pad layout and pixel bundles
// imported by every module of the clk_74a datapath

package starforce_pkg;

    //////////////////////////////
    // bridge
    //////////////////////////////

    typedef logic [31:0] bridge_word_t;

    // setting registers, one per address
    localparam bridge_word_t addr_lives      = 32'h2000_0000;
    localparam bridge_word_t addr_difficulty = 32'h3000_0000;
    localparam bridge_word_t addr_bonus      = 32'h4000_0000;
    localparam bridge_word_t addr_demo       = 32'h5000_0000;
    localparam bridge_word_t addr_reset      = 32'h8000_0000;
    localparam bridge_word_t addr_snac       = 32'hF200_0000;

    //////////////////////////////
    // adapter settings
    //////////////////////////////

    // which pad feeds which player
    typedef enum logic [1:0] {
        p1_to_p1     = 2'd0,
        p1_to_p2     = 2'd1,
        both_direct  = 2'd2,
        both_swapped = 2'd3
    } snac_assign_e;

    // field order matches the bridge data bits 4..0
    typedef struct packed {
        logic         blank_screen;
        snac_assign_e assign_mode;
        logic         analog;
        logic         enable;
    } snac_cfg_t;

    typedef struct packed {
        logic [1:0] lives;
        logic [2:0] difficulty;
        logic [2:0] bonus;
        logic       demo_sounds;
    } game_dips_t;

    //////////////////////////////
    // controls
    //////////////////////////////

    typedef logic [15:0] pad_keys_t;

    // bit positions in the key bitmap
    localparam int key_up    = 0;
    localparam int key_down  = 1;
    localparam int key_left  = 2;
    localparam int key_right = 3;
    localparam int key_fire  = 4;
    localparam int key_coin  = 14;
    localparam int key_start = 15;

    // stick x in [7:0], y in [15:8]
    typedef struct packed {
        pad_keys_t   keys;
        logic [31:0] stick;
    } snac_pad_t;

    // unsigned stick, centre near 0x80
    localparam logic [7:0] stick_low  = 8'h40;
    localparam logic [7:0] stick_high = 8'hC0;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic fire;
        logic start;
        logic coin;
    } arcade_ctrl_t;

    //////////////////////////////
    // video
    //////////////////////////////

    typedef struct packed {
        logic [11:0] rgb12;
        logic        hblank;
        logic        vblank;
        logic        hs;
        logic        vs;
    } pixel_in_t;

    typedef struct packed {
        logic [23:0] rgb24;
        logic        de;
        logic        hs;
        logic        vs;
    } pixel_out_t;

endpackage
